/* mix.f */
+incdir+include
verilog/mixIsaPkg.sv
verilog/mixCorePkg.sv
verilog/mixFieldUnit.sv
verilog/mixRegisterFile.sv
verilog/mixArith.sv
verilog/mixOutPort.sv
verilog/mixControl.sv
verilog/mix.sv
tb/mixTbModel.sv
tb/mixTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= mixTb
FILELIST ?= mix.f
OBJDIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard include/*.svh)
SIM := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJDIR)

/* tb/mixTb.sv */
//--------------------------------------------------------------------
// testbench for the MIX core: loads random programs, returns credits
// late and compares every output word with the reference model
//--------------------------------------------------------------------
`include "mix_params.svh"

module mixTb;
	timeunit 1ns;
	timeprecision 100ps;
	import mixIsaPkg::*;
	import mixTbModel::*;

	localparam int numProgs = 8;
	localparam int bodyLen = 40;
	localparam int progLen = bodyLen + 22;
	localparam int maxDelay = 63;
	localparam longint limitCycles = numProgs * (`MIX_MEM_WORDS + 20 * progLen
		+ progLen * maxDelay + 100);

	logic clk;
	logic reset;
	logic progWrite;
	logic [`MIX_ADDR_BITS-1:0] progAddr;
	mixWord_u progWord;
	logic run;
	logic halted;
	logic outValid;
	mixWord_u outWord;
	logic outCredit;
	longint cycle;
	longint due;
	longint dueQ [$];
	int outstanding;

	mix mix_i (.*);

	always #2 clk = ~clk;

	task automatic failNow(input string msg);
		$display("%s", msg);
		$display("Test FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic checkEqual(input logic [63:0] got, input logic [63:0] exp,
		input string what);
		if (got !== exp) begin
			$display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
			$display("Test FAILED");
			$fatal(1, "mismatch");
		end
	endtask

	task automatic applyReset();
		reset = 1'b1;
		repeat (3) @(negedge clk);
		reset = 1'b0;
	endtask

	always @(posedge clk)
		cycle <= cycle + 1;

	// sink: check words in order, return credits after random delays
	always @(negedge clk) begin
		if (reset) begin
			outCredit = 1'b0;
			dueQ.delete();
			outstanding = 0;
		end else begin
			outCredit = 1'b0;
			if (dueQ.size() > 0 && dueQ[0] <= cycle) begin
				outCredit = 1'b1;
				void'(dueQ.pop_front());
				outstanding--;
			end
			if (outValid) begin
				if (expOut.size() == 0) begin
					failNow("an output word appeared that the model does not expect");
				end else begin
					checkEqual(outWord, expOut.pop_front(), "output word");
					outstanding++;
					if (outstanding > `MIX_OUT_CREDITS) begin
						failNow("more words are outstanding than the port has credits");
					end else begin
						due = cycle + randBits(6);
						if (dueQ.size() > 0 && due <= dueQ[$])
							due = dueQ[$] + 1;
						dueQ.push_back(due);
					end
				end
			end
		end
	end

	initial begin
		#(limitCycles * 4);
		failNow("the core did not halt within the time limit");
	end

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		progWrite = 1'b0;
		progAddr = '0;
		progWord = '0;
		run = 1'b0;
		outCredit = 1'b0;
		cycle = 0;
		outstanding = 0;
		for (int p = 0; p < numProgs; p++) begin
			applyReset();
			checkEqual(halted, 1'b0, "halted after reset");
			checkEqual(outValid, 1'b0, "outValid after reset");
			void'(genProgram(bodyLen));
			runModel();
			for (int a = 0; a < `MIX_MEM_WORDS; a++) begin
				@(negedge clk);
				progWrite = 1'b1;
				progAddr = a[`MIX_ADDR_BITS-1:0];
				progWord = image[a];
			end
			@(negedge clk);
			progWrite = 1'b0;
			run = 1'b1;
			@(negedge clk);
			run = 1'b0;
			while (!halted)
				@(negedge clk);
			// no further words once halted
			repeat (30) begin
				@(negedge clk);
				checkEqual(halted, 1'b1, "halted stays high");
			end
			checkEqual(expOut.size(), 0, "words still expected");
		end
		applyReset();
		checkEqual(halted, 1'b0, "halted after reset");
		checkEqual(outValid, 1'b0, "outValid after reset");
		$display("Test OK");
		$finish;
	end

endmodule

/* tb/mixTbModel.sv */
//--------------------------------------------------------------------
// testbench side of the MIX core: LFSR, random program generator and
// an instruction-level reference model of the same memory image
//--------------------------------------------------------------------
`include "mix_params.svh"

package mixTbModel;
	import mixIsaPkg::*;

	logic [31:0] lfsr = 32'hfa27;
	mixWord_u image [`MIX_MEM_WORDS];
	mixWord_u work [`MIX_MEM_WORDS];
	mixWord_u expOut [$];
	mixWord_u regA;
	mixWord_u regX;
	logic [12:0] regI [1:6];
	logic [11:0] regJ;

	// galois form, one step per bit
	function automatic logic [31:0] randBits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h80200003 : lfsr >> 1;
		end
		return v;
	endfunction

	function automatic int randBelow(input int k);
		return randBits(8) % k;
	endfunction

	function automatic mixWord_u instr(input logic [5:0] op, input logic [5:0] f,
		input logic [11:0] addr, input logic [2:0] idx = 3'd0, input logic sign = 1'b0);
		mixWord_u w;
		w = {sign, addr, 3'b000, idx, f, op};
		return w;
	endfunction

	function automatic logic [5:0] randField();
		int l;
		int r;
		r = randBelow(6);
		l = randBelow(r + 1);
		return {l[2:0], r[2:0]};
	endfunction

	// forward only, at most to the start of the tail
	function automatic logic [11:0] target(input int pc, input int bodyLen);
		int t;
		t = pc + 2 + randBelow(3);
		if (t > bodyLen)
			t = bodyLen;
		return 12'(t);
	endfunction

	function automatic mixWord_u randInstr(input int pc, input int bodyLen);
		logic [3:0] kind;
		logic [2:0] r;
		logic [11:0] d;
		kind = randBits(4);
		r = randBits(3);
		d = 12'(1000 + randBits(6));
		case (kind)
			0, 1: return instr(6'(8 + r), randField(), d);
			2: return instr(6'(16 + r), randField(), d);
			3: return instr(6'(24 + r), randField(), d);
			4: return instr(6'd1, randField(), d);
			5: return instr(6'd2, randField(), d);
			6: return instr(6'(56 + r), randField(), d);
			7: return instr(6'd39, 6'(randBelow(10)), target(pc, bodyLen));
			8: return instr(6'(40 + r), 6'(randBelow(6)), target(pc, bodyLen));
			9, 10: return instr(6'(48 + r), 6'(randBelow(4)), randBits(12),
				3'(randBelow(7)), randBits(1));
			11: return instr(6'd37, 6'd5, d);
			12: return instr(6'd32, randField(), d);
			13: return instr(6'd33, randField(), d);
			14: return instr(randBits(1) ? 6'd5 : 6'd0, 6'd0, d);
			default: return instr(6'd1, 6'd5, d);
		endcase
	endfunction

	// random memory, random body, then stores, flag markers, OUTs and HLT
	function automatic int genProgram(input int bodyLen);
		int pc;
		for (int a = 0; a < `MIX_MEM_WORDS; a++)
			image[a] = randBits(31);
		for (pc = 0; pc < bodyLen; pc++)
			image[pc] = randInstr(pc, bodyLen);
		for (int r = 0; r < 8; r++)
			image[pc++] = instr(6'(24 + r), 6'd5, 12'(2000 + r));
		image[pc++] = instr(6'd32, 6'd5, 12'd2008);
		image[pc] = instr(6'd39, 6'd2, 12'(pc + 2));
		pc++;
		image[pc++] = instr(6'd37, 6'd5, 12'd1998);
		image[pc++] = instr(6'd37, 6'd5, 12'd1999);
		for (int k = 0; k < 9; k++)
			image[pc++] = instr(6'd37, 6'd5, 12'(2000 + k));
		image[pc++] = instr(6'd5, 6'd2, 12'd0);
		return pc;
	endfunction

	function automatic longint smValue(input mixWord_u w);
		longint m;
		m = longint'(w[29:0]);
		return w[30] ? -m : m;
	endfunction

	function automatic mixWord_u fieldGet(input mixWord_u w, input logic [5:0] f);
		int l;
		int r;
		int first;
		int shift;
		longint mask;
		mixWord_u x;
		l = f[5:3];
		r = f[2:0];
		first = (l == 0) ? 1 : l;
		shift = 6 * (5 - r);
		mask = (longint'(1) << (6 * (r - first + 1))) - 1;
		x = '0;
		x[29:0] = 30'((longint'(w[29:0]) >> shift) & mask);
		if (l == 0)
			x[30] = w[30];
		return x;
	endfunction

	function automatic mixWord_u fieldPut(input mixWord_u m, input logic [5:0] f,
		input mixWord_u v);
		int l;
		int r;
		int first;
		int shift;
		longint mask;
		mixWord_u x;
		l = f[5:3];
		r = f[2:0];
		first = (l == 0) ? 1 : l;
		shift = 6 * (5 - r);
		mask = ((longint'(1) << (6 * (r - first + 1))) - 1) << shift;
		x = m;
		x[29:0] = 30'((longint'(m[29:0]) & ~mask) | ((longint'(v[29:0]) << shift) & mask));
		if (l == 0)
			x[30] = v[30];
		return x;
	endfunction

	// a zero magnitude keeps the sign of a
	function automatic mixWord_u addSm(input mixWord_u a, input mixWord_u b,
		input logic sub, output logic ovf);
		longint s;
		longint mag;
		mixWord_u x;
		s = smValue(a) + (sub ? -smValue(b) : smValue(b));
		mag = (s < 0) ? -s : s;
		ovf = (mag >> 30) != 0;
		x[29:0] = mag[29:0];
		x[30] = (mag[29:0] == 0) ? a[30] : (s < 0);
		return x;
	endfunction

	function automatic mixWord_u getReg(input logic [2:0] r);
		if (r == 0)
			return regA;
		if (r == 7)
			return regX;
		return {regI[r][12], 18'b0, regI[r][11:0]};
	endfunction

	function automatic void setReg(input logic [2:0] r, input mixWord_u w);
		if (r == 0)
			regA = w;
		else if (r == 7)
			regX = w;
		else
			regI[r] = {w[30], w[11:0]};
	endfunction

	// runs the image until HLT and fills expOut
	function automatic void runModel();
		mixWord_u inst;
		mixWord_u m;
		mixWord_u v;
		mixWord_u eaWord;
		logic [5:0] op;
		logic [5:0] f;
		logic [2:0] r;
		logic [2:0] idx;
		logic [11:0] pc;
		logic [11:0] ea;
		logic [11:0] next;
		logic ovf;
		logic o;
		logic taken;
		logic z;
		longint as;
		longint iv;
		int cmp;
		work = image;
		expOut.delete();
		regA = '0;
		regX = '0;
		regJ = '0;
		for (int i = 1; i <= 6; i++)
			regI[i] = '0;
		ovf = 0;
		cmp = 0;
		pc = 0;
		for (int step = 0; step < `MIX_MEM_WORDS; step++) begin
			inst = work[pc];
			op = inst.instr.opcode;
			f = inst.instr.field;
			r = op[2:0];
			idx = inst.instr.index;
			as = longint'(inst.instr.addr);
			if (inst.instr.sign)
				as = -as;
			iv = 0;
			if (idx >= 1 && idx <= 6) begin
				iv = longint'(regI[idx][11:0]);
				if (regI[idx][12])
					iv = -iv;
			end
			ea = 12'(as + iv);
			m = (ea < `MIX_MEM_WORDS) ? work[ea] : '0;
			eaWord = {19'b0, ea};
			next = pc + 1;
			taken = 0;
			if (op == 5 && f == 2)
				return;
			if (op == 1 || op == 2) begin
				regA = addSm(regA, fieldGet(m, f), op == 2, o);
				if (o)
					ovf = 1;
			end else if (op >= 8 && op <= 15) begin
				setReg(r, fieldGet(m, f));
			end else if (op >= 16 && op <= 23) begin
				v = fieldGet(m, f);
				v[30] = ~v[30];
				setReg(r, v);
			end else if (op >= 24 && op <= 31) begin
				work[ea] = fieldPut(m, f, getReg(r));
			end else if (op == 32) begin
				work[ea] = fieldPut(m, f, {19'b0, regJ});
			end else if (op == 33) begin
				work[ea] = fieldPut(m, f, '0);
			end else if (op == 37) begin
				expOut.push_back(m);
			end else if (op == 39) begin
				case (f)
					0, 1: taken = 1;
					2: taken = ovf;
					3: taken = !ovf;
					4: taken = cmp < 0;
					5: taken = cmp == 0;
					6: taken = cmp > 0;
					7: taken = cmp >= 0;
					8: taken = cmp != 0;
					9: taken = cmp <= 0;
					default: taken = 0;
				endcase
				if (f == 2 || f == 3)
					ovf = 0;
			end else if (op >= 40 && op <= 47) begin
				v = getReg(r);
				z = v[29:0] == 0;
				case (f)
					0: taken = v[30] && !z;
					1: taken = z;
					2: taken = !v[30] && !z;
					3: taken = !v[30] || z;
					4: taken = !z;
					5: taken = v[30] || z;
					default: taken = 0;
				endcase
			end else if (op >= 48 && op <= 55) begin
				if (f <= 1) begin
					setReg(r, addSm(getReg(r), eaWord, f == 1, o));
					if (o && (r == 0 || r == 7))
						ovf = 1;
				end else if (f == 2) begin
					setReg(r, eaWord);
				end else if (f == 3) begin
					eaWord[30] = 1'b1;
					setReg(r, eaWord);
				end
			end else if (op >= 56) begin
				as = smValue(fieldGet(getReg(r), f));
				iv = smValue(fieldGet(m, f));
				cmp = (as < iv) ? -1 : ((as > iv) ? 1 : 0);
			end
			if (taken) begin
				if (!(op == 39 && f == 1))
					regJ = pc + 1;
				next = ea;
			end
			pc = next;
		end
	endfunction

endpackage

/* verilog/mix.sv */
//--------------------------------------------------------------------
// reduced MIX computer: load a program, pulse run, read words from
// the credit-based output channel until halted
//--------------------------------------------------------------------
`include "mix_params.svh"

module mix (
	input logic clk,
	input logic reset,
	input logic progWrite,
	input logic [`MIX_ADDR_BITS-1:0] progAddr,
	input mixIsaPkg::mixWord_u progWord,
	input logic run,
	output logic halted,
	output logic outValid,
	output mixIsaPkg::mixWord_u outWord,
	input logic outCredit
);
	import mixIsaPkg::*;
	import mixCorePkg::*;

	regSel_e readSel;
	regSel_e writeSel;
	mixWord_u readValue;
	mixWord_u writeValue;
	mixWord_u fuWord;
	mixWord_u fuRegValue;
	mixWord_u fuExtracted;
	mixWord_u fuMerged;
	mixWord_u arA;
	mixWord_u arB;
	mixWord_u arSum;
	mixWord_u outData;
	fieldSpec_t fuField;
	logic writeEnable;
	logic jWrite;
	logic arSubtract;
	logic arOverflow;
	logic arLess;
	logic arEqual;
	logic arGreater;
	logic outStart;
	logic outReady;
	logic [`MIX_ADDR_BITS-1:0] jValue;
	logic [`MIX_ADDR_BITS-1:0] jValueOut;
	logic [`MIX_ADDR_BITS-1:0] effAddr;
	logic [`MIX_ADDR_BITS:0] addrField;
	logic [2:0] indexSel;

	mixControl control_i (.*);

	mixRegisterFile regFile_i (.*);

	mixFieldUnit fieldUnit_i (
		.word(fuWord),
		.field(fuField),
		.regValue(fuRegValue),
		.extracted(fuExtracted),
		.merged(fuMerged)
	);

	mixArith arith_i (
		.a(arA),
		.b(arB),
		.subtract(arSubtract),
		.sum(arSum),
		.overflow(arOverflow),
		.less(arLess),
		.equal(arEqual),
		.greater(arGreater)
	);

	mixOutPort outPort_i (.*);

endmodule

/* verilog/mixControl.sv */
//--------------------------------------------------------------------
// MIX sequencer: memory and load port, fetch/decode/execute, flags,
// jump conditions and write-back selection
//--------------------------------------------------------------------
`include "mix_params.svh"

module mixControl (
	input logic clk,
	input logic reset,
	input logic progWrite,
	input logic [`MIX_ADDR_BITS-1:0] progAddr,
	input mixIsaPkg::mixWord_u progWord,
	input logic run,
	output logic halted,
	output mixCorePkg::regSel_e readSel,
	input mixIsaPkg::mixWord_u readValue,
	output mixCorePkg::regSel_e writeSel,
	output logic writeEnable,
	output mixIsaPkg::mixWord_u writeValue,
	output logic jWrite,
	output logic [`MIX_ADDR_BITS-1:0] jValue,
	input logic [`MIX_ADDR_BITS-1:0] jValueOut,
	output logic [2:0] indexSel,
	output logic [`MIX_ADDR_BITS:0] addrField,
	input logic [`MIX_ADDR_BITS-1:0] effAddr,
	output mixIsaPkg::mixWord_u fuWord,
	output mixIsaPkg::fieldSpec_t fuField,
	output mixIsaPkg::mixWord_u fuRegValue,
	input mixIsaPkg::mixWord_u fuExtracted,
	input mixIsaPkg::mixWord_u fuMerged,
	output mixIsaPkg::mixWord_u arA,
	output mixIsaPkg::mixWord_u arB,
	output logic arSubtract,
	input mixIsaPkg::mixWord_u arSum,
	input logic arOverflow,
	input logic arLess,
	input logic arEqual,
	input logic arGreater,
	output logic outStart,
	input logic outReady,
	output mixIsaPkg::mixWord_u outData
);
	import mixIsaPkg::*;
	import mixCorePkg::*;

	localparam int padBits = 30 - `MIX_ADDR_BITS;

	mixWord_u mem [`MIX_MEM_WORDS];
	mixWord_u memData;
	mixWord_u ir;
	mixWord_u inst;
	mixWord_u cmpLhs;
	mixWord_u addrWord;
	mixWord_u jWord;
	cpuState_e state;
	logic [`MIX_ADDR_BITS-1:0] pc;
	logic [`MIX_ADDR_BITS-1:0] memAddr;
	logic [5:0] op;
	logic [5:0] fieldBits;
	logic runQ;
	logic overflowFlag;
	logic lessFlag;
	logic equalFlag;
	logic greaterFlag;
	logic isAdd, isSub, isHlt, isLd, isLdn, isSt, isStj, isStz;
	logic isOut, isJmp, isJreg, isAddr, isCmp;
	logic jmpCond, regCond, jumpTaken, execDone;
	logic regZero;

	// the instruction arrives on memData in DECODE and sits in ir afterwards
	assign inst = (state == DECODE) ? memData : ir;
	assign op = inst.instr.opcode;
	assign fieldBits = inst.instr.field;

	assign isAdd = op == OP_ADD;
	assign isSub = op == OP_SUB;
	assign isHlt = (op == OP_SPECIAL) && (fieldBits == FIELD_HLT);
	assign isLd = {op[5:3], 3'b000} == OP_LD;
	assign isLdn = {op[5:3], 3'b000} == OP_LDN;
	assign isSt = {op[5:3], 3'b000} == OP_ST;
	assign isStj = op == OP_STJ;
	assign isStz = op == OP_STZ;
	assign isOut = op == OP_OUT;
	assign isJmp = op == OP_JMP;
	assign isJreg = {op[5:3], 3'b000} == OP_JREG;
	assign isAddr = {op[5:3], 3'b000} == OP_ADDR;
	assign isCmp = {op[5:3], 3'b000} == OP_CMP;

	assign indexSel = inst.instr.index;
	assign addrField = {inst.instr.sign, inst.instr.addr};
	assign readSel = (isAdd || isSub) ? REG_A : regSel_e'(op[2:0]);
	assign writeSel = readSel;

	assign addrWord = {1'b0, {padBits{1'b0}}, effAddr};
	assign jWord = {1'b0, {padBits{1'b0}}, jValueOut};

	// DECODE extracts the CMP register field, EXECUTE works on M
	assign fuWord = (state == DECODE) ? readValue : memData;
	assign fuField = inst.instr.field;
	assign fuRegValue = isStj ? jWord : (isStz ? '0 : readValue);

	assign arA = isCmp ? cmpLhs : readValue;
	assign arB = isAddr ? addrWord : fuExtracted;
	assign arSubtract = isSub || (isAddr && fieldBits == 6'd1);

	assign regZero = readValue[29:0] == '0;

	always_comb begin
		case (fieldBits)
			6'd0, 6'd1: jmpCond = 1'b1;
			6'd2: jmpCond = overflowFlag;
			6'd3: jmpCond = !overflowFlag;
			6'd4: jmpCond = lessFlag;
			6'd5: jmpCond = equalFlag;
			6'd6: jmpCond = greaterFlag;
			6'd7: jmpCond = !lessFlag;
			6'd8: jmpCond = !equalFlag;
			6'd9: jmpCond = !greaterFlag;
			default: jmpCond = 1'b0;
		endcase
		// N, Z, P, NN, NZ, NP with -0 counted as zero
		case (fieldBits)
			6'd0: regCond = readValue.data.sign && !regZero;
			6'd1: regCond = regZero;
			6'd2: regCond = !readValue.data.sign && !regZero;
			6'd3: regCond = !readValue.data.sign || regZero;
			6'd4: regCond = !regZero;
			6'd5: regCond = readValue.data.sign || regZero;
			default: regCond = 1'b0;
		endcase
	end

	assign jumpTaken = (isJmp && jmpCond) || (isJreg && regCond);
	// OUT waits in EXECUTE until a credit is free
	assign execDone = (state == EXECUTE) && (!isOut || outReady);
	assign outStart = (state == EXECUTE) && isOut && outReady;
	assign outData = memData;
	assign halted = state == HALTED;

	always_comb begin
		writeValue = fuExtracted;
		if (isLdn)
			writeValue = {~fuExtracted.data.sign, fuExtracted[29:0]};
		else if (isAdd || isSub || (isAddr && fieldBits[1] == 1'b0))
			writeValue = arSum;
		else if (isAddr && fieldBits == 6'd2)
			writeValue = addrWord;
		else if (isAddr)
			writeValue = {1'b1, addrWord[29:0]};
	end

	assign writeEnable = execDone && (isLd || isLdn || isAdd || isSub ||
		(isAddr && fieldBits <= 6'd3));
	assign jWrite = execDone && jumpTaken && !(isJmp && fieldBits == 6'd1);
	assign jValue = pc + 1'b1;

	assign memAddr = (state == FETCH) ? pc : effAddr;

	always_ff @(posedge clk) begin
		if (execDone && (isSt || isStj || isStz))
			mem[effAddr] <= fuMerged;
		else if (progWrite)
			mem[progAddr] <= progWord;
		memData <= mem[memAddr];
		if (state == DECODE) begin
			ir <= memData;
			cmpLhs <= fuExtracted;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
			pc <= '0;
			runQ <= 1'b0;
			overflowFlag <= 1'b0;
			lessFlag <= 1'b0;
			equalFlag <= 1'b1;
			greaterFlag <= 1'b0;
		end else begin
			runQ <= run;
			case (state)
				IDLE: begin
					if (run && !runQ) begin
						state <= FETCH;
						pc <= '0;
					end
				end
				FETCH: state <= DECODE;
				DECODE: state <= EXECUTE;
				EXECUTE: begin
					if (execDone) begin
						state <= isHlt ? HALTED : FETCH;
						pc <= jumpTaken ? effAddr : jValue;
					end
				end
				default: state <= state;
			endcase
			if (execDone) begin
				// index registers never touch overflow
				if ((isAdd || isSub) && arOverflow)
					overflowFlag <= 1'b1;
				else if (isAddr && fieldBits <= 6'd1 && (writeSel == REG_A || writeSel == REG_X)
					&& arOverflow)
					overflowFlag <= 1'b1;
				else if (isJmp && (fieldBits == 6'd2 || fieldBits == 6'd3))
					overflowFlag <= 1'b0;
				if (isCmp) begin
					lessFlag <= arLess;
					equalFlag <= arEqual;
					greaterFlag <= arGreater;
				end
			end
		end
	end

	loadWhileIdle: assert property (@(posedge clk) disable iff (reset)
		progWrite |-> state == IDLE);

endmodule

/* verilog/mixOutPort.sv */
//--------------------------------------------------------------------
// OUT channel: presents one word per send to the sink and tracks
// the credits that the sink returns
//--------------------------------------------------------------------
`include "mix_params.svh"

module mixOutPort (
	input logic clk,
	input logic reset,
	input logic outStart,
	input mixIsaPkg::mixWord_u outData,
	output logic outReady,
	output logic outValid,
	output mixIsaPkg::mixWord_u outWord,
	input logic outCredit
);

	localparam int creditBits = $clog2(`MIX_OUT_CREDITS + 1);
	localparam logic [creditBits-1:0] maxCredits = creditBits'(`MIX_OUT_CREDITS);

	logic [creditBits-1:0] credits;
	logic send;

	assign outReady = credits != '0;
	assign send = outStart && outReady;

	always_ff @(posedge clk) begin
		if (reset) begin
			credits <= maxCredits;
			outValid <= 1'b0;
		end else begin
			outValid <= send;
			// a send and a returned credit in one cycle cancel out
			case ({send, outCredit})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (send)
			outWord <= outData;
	end

	// sink must not return more credits than words it received
	creditLimit: assert property (@(posedge clk) disable iff (reset) credits <= maxCredits);
	creditReturn: assert property (@(posedge clk) disable iff (reset)
		outCredit |-> credits != maxCredits);

endmodule

/* verilog/mixArith.sv */
//--------------------------------------------------------------------
// sign-magnitude adder/subtracter with overflow, and the signed
// three-way compare used by CMPr
//--------------------------------------------------------------------
module mixArith (
	input mixIsaPkg::mixWord_u a,
	input mixIsaPkg::mixWord_u b,
	input logic subtract,
	output mixIsaPkg::mixWord_u sum,
	output logic overflow,
	output logic less,
	output logic equal,
	output logic greater
);

	logic bSign;
	logic [30:0] magSum;
	logic aBigger;
	logic signed [31:0] aValue;
	logic signed [31:0] bValue;

	// -0 maps onto 0 here
	function automatic logic signed [31:0] toSigned(input logic [30:0] w);
		logic signed [31:0] mag;
		mag = $signed({2'b00, w[29:0]});
		toSigned = w[30] ? -mag : mag;
	endfunction

	assign bSign = b.data.sign ^ subtract;
	assign magSum = {1'b0, a[29:0]} + {1'b0, b[29:0]};
	assign aBigger = a[29:0] >= b[29:0];

	always_comb begin
		overflow = 1'b0;
		if (a.data.sign == bSign) begin
			sum = {a.data.sign, magSum[29:0]};
			overflow = magSum[30];
		end else if (aBigger) begin
			// a zero difference lands here and keeps the sign of a
			sum = {a.data.sign, a[29:0] - b[29:0]};
		end else begin
			sum = {bSign, b[29:0] - a[29:0]};
		end
	end

	assign aValue = toSigned(a);
	assign bValue = toSigned(b);

	assign less = aValue < bValue;
	assign equal = aValue == bValue;
	assign greater = aValue > bValue;

endmodule

/* verilog/mixRegisterFile.sv */
//--------------------------------------------------------------------
// MIX registers A, X, I1-I6 and J with one read port, one write port
// and the indexed effective address of the current instruction
//--------------------------------------------------------------------
`include "mix_params.svh"

module mixRegisterFile (
	input logic clk,
	input logic reset,
	input mixCorePkg::regSel_e readSel,
	output mixIsaPkg::mixWord_u readValue,
	input mixCorePkg::regSel_e writeSel,
	input logic writeEnable,
	input mixIsaPkg::mixWord_u writeValue,
	input logic jWrite,
	input logic [`MIX_ADDR_BITS-1:0] jValue,
	output logic [`MIX_ADDR_BITS-1:0] jValueOut,
	input logic [2:0] indexSel,
	input logic [`MIX_ADDR_BITS:0] addrField,
	output logic [`MIX_ADDR_BITS-1:0] effAddr
);
	import mixCorePkg::*;

	localparam int padBits = 30 - `MIX_ADDR_BITS;

	logic [30:0] regA;
	logic [30:0] regX;
	logic [`MIX_ADDR_BITS:0] regI [1:6];
	logic [`MIX_ADDR_BITS-1:0] regJ;
	logic [`MIX_ADDR_BITS:0] indexValue;

	// sign-magnitude to two's complement, modulo the address range
	function automatic logic [`MIX_ADDR_BITS-1:0] toTwos(input logic [`MIX_ADDR_BITS:0] sm);
		toTwos = sm[`MIX_ADDR_BITS] ? ~sm[`MIX_ADDR_BITS-1:0] + 1'b1 : sm[`MIX_ADDR_BITS-1:0];
	endfunction

	always_comb begin
		case (readSel)
			REG_A: readValue = regA;
			REG_X: readValue = regX;
			default: readValue = {regI[readSel][`MIX_ADDR_BITS], {padBits{1'b0}},
				regI[readSel][`MIX_ADDR_BITS-1:0]};
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			regA <= '0;
			regX <= '0;
			regJ <= '0;
			for (int i = 1; i <= 6; i++)
				regI[i] <= '0;
		end else begin
			if (writeEnable) begin
				case (writeSel)
					REG_A: regA <= writeValue;
					REG_X: regX <= writeValue;
					// index registers keep the sign and 12 bits
					default: regI[writeSel] <= {writeValue[30], writeValue[`MIX_ADDR_BITS-1:0]};
				endcase
			end
			if (jWrite)
				regJ <= jValue;
		end
	end

	// index 0 and 7 mean no indexing
	always_comb begin
		if (indexSel inside {[3'd1:3'd6]})
			indexValue = regI[indexSel];
		else
			indexValue = '0;
	end

	assign effAddr = toTwos(addrField) + toTwos(indexValue);
	assign jValueOut = regJ;

endmodule

/* verilog/mixFieldUnit.sv */
//--------------------------------------------------------------------
// (L:R) field logic of MIX: extracts a field for loads and operands,
// and merges a register into a field for stores
//--------------------------------------------------------------------
module mixFieldUnit (
	input mixIsaPkg::mixWord_u word,
	input mixIsaPkg::fieldSpec_t field,
	input mixIsaPkg::mixWord_u regValue,
	output mixIsaPkg::mixWord_u extracted,
	output mixIsaPkg::mixWord_u merged
);

	logic [2:0] firstByte;
	logic validField;

	// byte range starts at 1 even when the sign is included
	assign firstByte = (field.l == 3'd0) ? 3'd1 : field.l;
	assign validField = (field.r <= 3'd5) && (field.l <= field.r);

	always_comb begin
		extracted = '0;
		merged = word;
		if (field.l == 3'd0) begin
			extracted.data.sign = word.data.sign;
			merged.data.sign = regValue.data.sign;
		end
		for (int i = 1; i <= 5; i++) begin
			if (validField && i >= firstByte && i <= field.r) begin
				// byte R lands in byte 5, the others to its left
				extracted.data.bytes[5 - field.r + i] = word.data.bytes[i];
				merged.data.bytes[i] = regValue.data.bytes[5 - field.r + i];
			end
		end
	end

endmodule

/* verilog/mixCorePkg.sv */
//--------------------------------------------------------------------
// types private to this MIX core: register selector and sequencer
//--------------------------------------------------------------------
package mixCorePkg;

	// matches the low three opcode bits
	typedef enum logic [2:0] {
		REG_A = 3'd0,
		REG_I1 = 3'd1,
		REG_I2 = 3'd2,
		REG_I3 = 3'd3,
		REG_I4 = 3'd4,
		REG_I5 = 3'd5,
		REG_I6 = 3'd6,
		REG_X = 3'd7
	} regSel_e;

	typedef enum logic [2:0] {
		IDLE,
		FETCH,
		DECODE,
		EXECUTE,
		HALTED
	} cpuState_e;

endpackage

/* verilog/mixIsaPkg.sv */
//--------------------------------------------------------------------
// MIX instruction set types: word layout, opcodes and field specs
//--------------------------------------------------------------------
package mixIsaPkg;

	// F = 8L + R
	typedef struct packed {
		logic [2:0] l;
		logic [2:0] r;
	} fieldSpec_t;

	typedef struct packed {
		logic sign;
		logic [11:0] addr;
		logic [2:0] unused;
		logic [2:0] index;
		fieldSpec_t field;
		logic [5:0] opcode;
	} mixInstr_t;

	// byte 1 is the most significant
	typedef struct packed {
		logic sign;
		logic [1:5][5:0] bytes;
	} mixData_t;

	typedef union packed {
		mixInstr_t instr;
		mixData_t data;
	} mixWord_u;

	// single opcodes and the bases of the 8-wide groups
	typedef enum logic [5:0] {
		OP_NOP = 6'd0,
		OP_ADD = 6'd1,
		OP_SUB = 6'd2,
		OP_SPECIAL = 6'd5,
		OP_LD = 6'd8,
		OP_LDN = 6'd16,
		OP_ST = 6'd24,
		OP_STJ = 6'd32,
		OP_STZ = 6'd33,
		OP_OUT = 6'd37,
		OP_JMP = 6'd39,
		OP_JREG = 6'd40,
		OP_ADDR = 6'd48,
		OP_CMP = 6'd56
	} opcode_e;

	// field of opcode 5 that halts
	localparam logic [5:0] FIELD_HLT = 6'd2;

endpackage

/* include/mix_params.svh */
//--------------------------------------------------------------------
// sizes shared by the MIX core and its testbench
// include wherever memory depth, address width or credits are needed
//--------------------------------------------------------------------
`ifndef MIX_PARAMS_SVH
`define MIX_PARAMS_SVH

// memory words, address bits and output credits
`define MIX_MEM_WORDS 4000
`define MIX_ADDR_BITS 12
`define MIX_OUT_CREDITS 4

`endif
